//--- verilog.f
source/console_pkg.sv
source/console_dpram.sv
source/cmds_scan.sv
source/cmd_queue.sv
source/datas_scan.sv
source/console.sv
bench/tb_clkgen.sv
bench/console_tb.sv

//--- Bender.yml
package:
  name: console

sources:
  - files:
      - source/console_pkg.sv
      - source/console_dpram.sv
      - source/cmds_scan.sv
      - source/cmd_queue.sv
      - source/datas_scan.sv
      - source/console.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/console_tb.sv

//--- bench/console_tb.sv
/*
 * register model holds 256 bytes indexed by the low address byte
 * every bus strobe is also checked against the expected full address
 */
`default_nettype none

module console_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import console_pkg::*;

	wire                clk;
	wire                rst_n;
	logic               i_con_en;
	logic               i_cmd_wren;
	logic [CMD_AW-1:0]  i_cmd_addr;
	logic [7:0]         i_cmd_din;
	wire  [7:0]         o_cmd_dout;
	logic [RESP_AW-1:0] i_resp_addr;
	wire  [7:0]         o_resp_dout;
	wire                o_reg_wren;
	wire                o_reg_rden;
	wire  [REG_AW-1:0]  o_reg_addr;
	wire  [7:0]         o_reg_wdata;
	logic [7:0]         i_reg_rdata;
	logic               i_reg_wait;
	wire                o_busy;
	wire                o_done;
	wire                o_error;

	logic [7:0]  reg_mem [256];
	logic [7:0]  shadow [256];
	logic [7:0]  rd_next = 8'h00;
	logic [31:0] lfsr = 32'h1a44;
	int          errors = 0;
	int          checks = 0;
	int          strobes = 0;
	int          full_cycles = 0;
	logic        wait_on = 1'b0;
	logic        batch_active = 1'b0;
	int          batch_cycles;
	int          batch_limit = 200;

	// ==================================================
	// current batch and its expected results
	// ==================================================

	logic [7:0]  rec_op [MAX_RECORDS];
	logic [15:0] rec_addr [MAX_RECORDS];
	logic [7:0]  rec_data [MAX_RECORDS];
	logic [7:0]  exp_resp [MAX_RECORDS];
	logic        exp_error;
	logic [15:0] bus_addr_q [$];

	tb_clkgen u_clkgen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	console dut_i (
		.clk         (clk),
		.i_rst_n     (rst_n),
		.i_con_en    (i_con_en),
		.i_cmd_wren  (i_cmd_wren),
		.i_cmd_addr  (i_cmd_addr),
		.i_cmd_din   (i_cmd_din),
		.o_cmd_dout  (o_cmd_dout),
		.i_resp_addr (i_resp_addr),
		.o_resp_dout (o_resp_dout),
		.o_reg_wren  (o_reg_wren),
		.o_reg_rden  (o_reg_rden),
		.o_reg_addr  (o_reg_addr),
		.o_reg_wdata (o_reg_wdata),
		.i_reg_rdata (i_reg_rdata),
		.i_reg_wait  (i_reg_wait),
		.o_busy      (o_busy),
		.o_done      (o_done),
		.o_error     (o_error)
	);

	// galois lfsr with taps 32 22 2 1 and one step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37) ^ 8'h5A;
	endfunction

	// executor rules applied to the shadow registers
	function automatic logic [7:0] expected_resp(input logic [7:0] op, input logic [15:0] addr,
			input logic [7:0] data);
		logic [7:0] a;
		a = addr[7:0];
		case (op)
			8'd0: return 8'h00;
			8'd1: begin
				shadow[a] = data;
				return data;
			end
			8'd2: return shadow[a];
			8'd3: begin
				shadow[a] = shadow[a] | data;
				return shadow[a];
			end
			default: return 8'hEE;
		endcase
	endfunction

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic host_write(input logic [CMD_AW-1:0] a, input logic [7:0] d);
		i_cmd_wren = 1'b1;
		i_cmd_addr = a;
		i_cmd_din  = d;
		step();
		i_cmd_wren = 1'b0;
	endtask

	task automatic load_batch(input int n);
		host_write('0, 8'(n));
		exp_error = 1'b0;
		bus_addr_q.delete();
		for (int k = 0; k < n; k++) begin
			host_write(CMD_AW'(4 * k + 4), rec_op[k]);
			host_write(CMD_AW'(4 * k + 5), rec_addr[k][15:8]);
			host_write(CMD_AW'(4 * k + 6), rec_addr[k][7:0]);
			host_write(CMD_AW'(4 * k + 7), rec_data[k]);
			exp_resp[k] = expected_resp(rec_op[k], rec_addr[k], rec_data[k]);
			if (rec_op[k] > 8'd3) begin
				exp_error = 1'b1;
			end
			// write, read and the read half of read-modify-write
			if (rec_op[k] >= 8'd1 && rec_op[k] <= 8'd3) begin
				bus_addr_q.push_back(rec_addr[k]);
			end
			// write back to the same address
			if (rec_op[k] == 8'd3) begin
				bus_addr_q.push_back(rec_addr[k]);
			end
		end
	endtask

	task automatic make_random(input int n);
		logic [7:0] b;
		logic [7:0] hi;
		logic [7:0] lo;
		for (int k = 0; k < n; k++) begin
			b  = rand_bits(3);
			hi = rand_bits(8);
			lo = rand_bits(4);
			// one in eight records gets an illegal opcode
			rec_op[k]   = (b == 8'd7) ? 8'hA5 : {6'd0, b[1:0]};
			rec_addr[k] = {hi, 4'h3, lo[3:0]};
			rec_data[k] = rand_bits(8);
		end
	endtask

	task automatic run_batch(input int n, input bit extra_start);
		int s0;
		int want;
		batch_limit  = 12 * n + 200;
		batch_active = 1'b1;
		s0   = strobes;
		want = bus_addr_q.size();
		i_con_en = 1'b1;
		step();
		i_con_en = 1'b0;
		check_eq("o_busy after start", o_busy, 1);
		check_eq("o_error after start", o_error, 0);
		if (extra_start) begin
			// scanner is idle again while the executor drains the queue
			while (!(dut_i.scan_done && o_busy)) begin
				step();
			end
			i_con_en = 1'b1;
			step();
			i_con_en = 1'b0;
		end
		do begin
			@(negedge clk);
		end while (!o_done);
		batch_active = 1'b0;
		check_eq("o_busy at o_done", o_busy, 0);
		check_eq("o_error at o_done", o_error, exp_error);
		check_eq("bus strobes in batch", strobes - s0, want);
		step();
	endtask

	task automatic check_batch(input int n);
		for (int k = 0; k < n; k++) begin
			i_resp_addr = RESP_AW'(k);
			step();
			check_eq($sformatf("response %0d", k), o_resp_dout, exp_resp[k]);
		end
		for (int a = 0; a < 256; a++) begin
			check_eq($sformatf("register %02h", a), reg_mem[a], shadow[a]);
		end
	endtask

	task automatic check_cmd_ram(input int n);
		logic [7:0] want;
		i_cmd_addr = '0;
		step();
		check_eq("command count byte", o_cmd_dout, n);
		for (int k = 0; k < n; k++) begin
			for (int j = 0; j < 4; j++) begin
				i_cmd_addr = CMD_AW'(4 * k + 4 + j);
				step();
				case (j)
					0: want = rec_op[k];
					1: want = rec_addr[k][15:8];
					2: want = rec_addr[k][7:0];
					default: want = rec_data[k];
				endcase
				check_eq($sformatf("command byte %0d", 4 * k + 4 + j), o_cmd_dout, want);
			end
		end
	endtask

	// ==================================================
	// register bus model and wait pattern
	// ==================================================

	// strobes are stable at the falling edge
	initial begin
		logic [15:0] want_addr;
		for (int a = 0; a < 256; a++) begin
			reg_mem[a] = fill_byte(a);
		end
		forever begin
			@(negedge clk);
			if (o_reg_wren) begin
				reg_mem[o_reg_addr[7:0]] = o_reg_wdata;
			end
			if (o_reg_rden) begin
				rd_next = reg_mem[o_reg_addr[7:0]];
			end
			if (o_reg_wren || o_reg_rden) begin
				strobes++;
				if (bus_addr_q.size() > 0) begin
					want_addr = bus_addr_q.pop_front();
					check_eq("register bus address", o_reg_addr, want_addr);
				end
			end
			if (dut_i.full) begin
				full_cycles++;
			end
		end
	end

	// read data in the cycle after the strobe
	initial begin
		i_reg_rdata = 8'h00;
		forever begin
			step();
			i_reg_rdata = rd_next;
		end
	end

	// long wait stretches with short gaps between them
	initial begin
		bit use_wait;
		bit level;
		int run;
		level = 1'b0;
		run   = 0;
		i_reg_wait = 1'b0;
		forever begin
			@(posedge clk);
			use_wait = wait_on;
			#2;
			if (!use_wait) begin
				level = 1'b0;
				run   = 0;
				i_reg_wait = 1'b0;
			end else begin
				if (run == 0) begin
					level = ~level;
					run   = level ? 1 + int'(rand_bits(4)) : 1 + int'(rand_bits(2));
				end
				i_reg_wait = level;
				run--;
			end
		end
	end

	initial begin
		batch_cycles = 0;
		while (batch_cycles <= batch_limit) begin
			@(posedge clk);
			batch_cycles = batch_active ? batch_cycles + 1 : 0;
		end
		$display("o_done did not arrive within %0d cycles of the start", batch_limit);
		$display("TESTS FAILED");
		$finish;
	end

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		int f0;
		i_con_en    = 1'b0;
		i_cmd_wren  = 1'b0;
		i_cmd_addr  = '0;
		i_cmd_din   = '0;
		i_resp_addr = '0;
		exp_error   = 1'b0;
		for (int a = 0; a < 256; a++) begin
			shadow[a] = fill_byte(a);
		end
		wait (rst_n === 1'b1);
		step();

		// quiet after reset, then an empty batch
		check_eq("o_busy after reset", o_busy, 0);
		check_eq("o_done after reset", o_done, 0);
		check_eq("o_error after reset", o_error, 0);
		check_eq("o_reg_wren after reset", o_reg_wren, 0);
		check_eq("o_reg_rden after reset", o_reg_rden, 0);
		check_eq("push after reset", dut_i.push, 0);
		check_eq("pop after reset", dut_i.pop, 0);
		load_batch(0);
		run_batch(0, 1'b0);

		// writes, then reads of the same registers
		for (int k = 0; k < 8; k++) begin
			rec_op[k]   = 8'd1;
			rec_addr[k] = {8'(k), 8'h10 + 8'(k)};
			rec_data[k] = 8'hC0 ^ 8'(k * 11);
		end
		load_batch(8);
		check_cmd_ram(8);
		run_batch(8, 1'b0);
		check_batch(8);
		for (int k = 0; k < 8; k++) begin
			rec_op[k]   = 8'd2;
			rec_data[k] = 8'hFF;
		end
		load_batch(8);
		run_batch(8, 1'b0);
		check_batch(8);

		// read-modify-write with the last register read back
		for (int k = 0; k < 5; k++) begin
			rec_op[k]   = 8'd3;
			rec_addr[k] = {8'h7F, 8'h10 + 8'(k)};
			rec_data[k] = 8'h01 << k;
		end
		rec_op[5]   = 8'd2;
		rec_addr[5] = 16'h0014;
		load_batch(6);
		run_batch(6, 1'b0);
		check_batch(6);

		// illegal opcodes, then a clean batch
		rec_op[0] = 8'd1;
		rec_op[1] = 8'd7;
		rec_op[2] = 8'd2;
		rec_op[3] = 8'd3;
		rec_op[4] = 8'hFF;
		rec_op[5] = 8'd1;
		for (int k = 0; k < 6; k++) begin
			rec_addr[k] = {8'h22, 8'h20 + 8'(k % 3)};
			rec_data[k] = 8'h3C + 8'(k);
		end
		load_batch(6);
		run_batch(6, 1'b0);
		check_batch(6);
		rec_op[0] = 8'd0;
		rec_op[1] = 8'd1;
		load_batch(2);
		run_batch(2, 1'b0);
		check_batch(2);

		// random batch against a slow bus
		make_random(40);
		load_batch(40);
		wait_on = 1'b1;
		f0 = full_cycles;
		run_batch(40, 1'b0);
		wait_on = 1'b0;
		check_batch(40);
		check_eq("queue reached full", (full_cycles - f0) > 0, 1);

		// second start while busy
		make_random(12);
		load_batch(12);
		wait_on = 1'b1;
		run_batch(12, 1'b1);
		wait_on = 1'b0;
		check_batch(12);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tb_clkgen.sv
/*
 * 20 ns clock and a synchronous active low reset held for 16 rising edges
 */
`default_nettype none

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	// half period of 10 ns
	initial begin
		o_clk = 1'b0;
		forever begin
			#10 o_clk = ~o_clk;
		end
	end

	// release 2 ns after the edge, like every other input
	initial begin
		o_rst_n = 1'b0;
		repeat (16) @(posedge o_clk);
		#2 o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- source/console.sv
/*
 * console engine top: command RAM, scanner, command queue, executor, response RAM
 * a start pulse while o_busy is high is dropped
 */
`default_nettype none

module console (
	input  wire                             clk,
	input  wire                             i_rst_n,
	input  wire                             i_con_en,

	// host side of the command RAM
	input  wire                             i_cmd_wren,
	input  wire [console_pkg::CMD_AW-1:0]   i_cmd_addr,
	input  wire [7:0]                       i_cmd_din,
	output wire [7:0]                       o_cmd_dout,

	// host side of the response RAM
	input  wire [console_pkg::RESP_AW-1:0]  i_resp_addr,
	output wire [7:0]                       o_resp_dout,

	// register bus
	output wire                             o_reg_wren,
	output wire                             o_reg_rden,
	output wire [console_pkg::REG_AW-1:0]   o_reg_addr,
	output wire [7:0]                       o_reg_wdata,
	input  wire [7:0]                       i_reg_rdata,
	input  wire                             i_reg_wait,

	output wire                             o_busy,
	output wire                             o_done,
	output wire                             o_error
);

	import console_pkg::*;

	// ==================================================
	// internal nets
	// ==================================================

	wire               con_start;
	wire [CMD_AW-1:0]  scan_addr;
	wire [7:0]         scan_data;
	wire               push;
	wire console_cmd_t push_cmd;
	wire               full;
	wire console_cmd_t head_cmd;
	wire               empty;
	wire               pop;
	wire               scan_done;
	wire               resp_wren;
	wire [RESP_AW-1:0] resp_addr;
	wire [7:0]         resp_din;

	// both engines see the same start, and none during a batch
	assign con_start = i_con_en & ~o_busy;

	// ==================================================
	// instances
	// ==================================================

	console_dpram #(
		.ADDR_W (CMD_AW)
	) u_cmd_ram (
		.clk      (clk),
		.i_a_wren (i_cmd_wren),
		.i_a_addr (i_cmd_addr),
		.i_a_din  (i_cmd_din),
		.o_a_dout (o_cmd_dout),
		.i_b_wren (1'b0),
		.i_b_addr (scan_addr),
		.i_b_din  (8'h00),
		.o_b_dout (scan_data)
	);

	cmds_scan u_cmds_scan (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_start     (con_start),
		.i_rd_data   (scan_data),
		.i_full      (full),
		.o_rd_addr   (scan_addr),
		.o_push      (push),
		.o_cmd       (push_cmd),
		.o_scan_done (scan_done)
	);

	cmd_queue u_cmd_queue (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_push  (push),
		.i_cmd   (push_cmd),
		.i_pop   (pop),
		.o_head  (head_cmd),
		.o_full  (full),
		.o_empty (empty)
	);

	datas_scan u_datas_scan (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_start     (con_start),
		.i_head      (head_cmd),
		.i_empty     (empty),
		.i_scan_done (scan_done),
		.i_reg_rdata (i_reg_rdata),
		.i_reg_wait  (i_reg_wait),
		.o_pop       (pop),
		.o_reg_wren  (o_reg_wren),
		.o_reg_rden  (o_reg_rden),
		.o_reg_addr  (o_reg_addr),
		.o_reg_wdata (o_reg_wdata),
		.o_resp_wren (resp_wren),
		.o_resp_addr (resp_addr),
		.o_resp_din  (resp_din),
		.o_busy      (o_busy),
		.o_done      (o_done),
		.o_error     (o_error)
	);

	// port a is the host read port, port b belongs to the executor
	console_dpram #(
		.ADDR_W (RESP_AW)
	) u_resp_ram (
		.clk      (clk),
		.i_a_wren (1'b0),
		.i_a_addr (i_resp_addr),
		.i_a_din  (8'h00),
		.o_a_dout (o_resp_dout),
		.i_b_wren (resp_wren),
		.i_b_addr (resp_addr),
		.i_b_din  (resp_din),
		.o_b_dout ()
	);

endmodule

`default_nettype wire

//--- source/datas_scan.sv
/*
 * executes queued commands on the byte register bus, one response byte each
 * read data is taken the cycle after o_reg_rden, whatever i_reg_wait does then
 */
`default_nettype none

module datas_scan (
	input  wire                             clk,
	input  wire                             i_rst_n,
	input  wire                             i_start,
	input  wire console_pkg::console_cmd_t  i_head,
	input  wire                             i_empty,
	input  wire                             i_scan_done,
	input  wire  [7:0]                      i_reg_rdata,
	input  wire                             i_reg_wait,
	output logic                            o_pop,
	output logic                            o_reg_wren,
	output logic                            o_reg_rden,
	output logic [console_pkg::REG_AW-1:0]  o_reg_addr,
	output logic [7:0]                      o_reg_wdata,
	output logic                            o_resp_wren,
	output logic [console_pkg::RESP_AW-1:0] o_resp_addr,
	output logic [7:0]                      o_resp_din,
	output logic                            o_busy,
	output logic                            o_done,
	output logic                            o_error
);

	import console_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		DISPATCH,
		READ_WAIT,
		OR_WRITE,
		FINISH
	} exec_state_e;

	exec_state_e  state;
	console_cmd_t cur_cmd;
	logic [7:0]   or_val;
	logic         dispatch_go;

	// take the head only when the bus is free
	assign dispatch_go = (state == DISPATCH) && !i_empty && !i_reg_wait;
	assign o_pop       = dispatch_go;

	// ==================================================
	// register bus strobes
	// ==================================================

	always_comb begin
		o_reg_wren  = 1'b0;
		o_reg_rden  = 1'b0;
		o_reg_addr  = cur_cmd.addr;
		o_reg_wdata = or_val;
		if (dispatch_go) begin
			o_reg_addr  = i_head.addr;
			o_reg_wdata = i_head.data;
			o_reg_wren  = (i_head.op == OP_WRITE);
			o_reg_rden  = (i_head.op == OP_READ) || (i_head.op == OP_OR);
		end else if (state == OR_WRITE && !i_reg_wait) begin
			// write back of the read-modify-write
			o_reg_wren = 1'b1;
		end
	end

	// ==================================================
	// fsm
	// ==================================================

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state       <= IDLE;
			o_busy      <= 1'b0;
			o_done      <= 1'b0;
			o_error     <= 1'b0;
			o_resp_wren <= 1'b0;
		end else begin
			o_done      <= 1'b0;
			o_resp_wren <= 1'b0;
			case (state)
				IDLE: begin
					if (i_start) begin
						o_busy  <= 1'b1;
						o_error <= 1'b0;
						state   <= DISPATCH;
					end
				end
				DISPATCH: begin
					if (dispatch_go) begin
						case (i_head.op)
							OP_READ, OP_OR: state <= READ_WAIT;
							OP_ILLEGAL: begin
								o_error     <= 1'b1;
								o_resp_wren <= 1'b1;
							end
							default: o_resp_wren <= 1'b1;
						endcase
					end else if (i_empty && i_scan_done) begin
						// last response write lands on this edge
						state <= FINISH;
					end
				end
				READ_WAIT: begin
					if (cur_cmd.op == OP_OR) begin
						state <= OR_WRITE;
					end else begin
						o_resp_wren <= 1'b1;
						state       <= DISPATCH;
					end
				end
				OR_WRITE: begin
					if (!i_reg_wait) begin
						o_resp_wren <= 1'b1;
						state       <= DISPATCH;
					end
				end
				FINISH: begin
					o_done <= 1'b1;
					o_busy <= 1'b0;
					state  <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// current command and response byte
	always_ff @(posedge clk) begin
		if (dispatch_go) begin
			cur_cmd     <= i_head;
			o_resp_addr <= i_head.idx;
			case (i_head.op)
				OP_WRITE:   o_resp_din <= i_head.data;
				OP_ILLEGAL: o_resp_din <= RESP_ILLEGAL;
				default:    o_resp_din <= 8'h00;
			endcase
		end
		if (state == READ_WAIT) begin
			or_val     <= i_reg_rdata | cur_cmd.data;
			o_resp_din <= (cur_cmd.op == OP_OR) ? (i_reg_rdata | cur_cmd.data) : i_reg_rdata;
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_reg_wren && o_reg_rden));

endmodule

`default_nettype wire

//--- source/cmd_queue.sv
/*
 * first-word-fall-through command FIFO, o_head is valid whenever o_empty is low
 * push and pop in the same cycle are allowed
 */
`default_nettype none

module cmd_queue (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  wire                            i_push,
	input  wire console_pkg::console_cmd_t i_cmd,
	input  wire                            i_pop,
	output console_pkg::console_cmd_t      o_head,
	output logic                           o_full,
	output logic                           o_empty
);

	import console_pkg::*;

	console_cmd_t        mem [QUEUE_DEPTH];
	logic [QUEUE_AW-1:0] wr_ptr;
	logic [QUEUE_AW-1:0] rd_ptr;
	logic [QUEUE_AW:0]   count;

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (i_push) begin
			mem[wr_ptr] <= i_cmd;
		end
	end

	assign o_head  = mem[rd_ptr];
	assign o_full  = (count == (QUEUE_AW + 1)'(QUEUE_DEPTH));
	assign o_empty = (count == '0);

	a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_full |-> !i_push);

	a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_empty |-> !i_pop);

endmodule

`default_nettype wire

//--- source/cmds_scan.sv
/*
 * reads the count byte, then four bytes per record, and pushes one command each
 * the command RAM must not change while a batch runs
 */
`default_nettype none

module cmds_scan (
	input  wire                            clk,
	input  wire                            i_rst_n,
	input  wire                            i_start,
	input  wire  [7:0]                     i_rd_data,
	input  wire                            i_full,
	output logic [console_pkg::CMD_AW-1:0] o_rd_addr,
	output logic                           o_push,
	output console_pkg::console_cmd_t      o_cmd,
	output logic                           o_scan_done
);

	import console_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		COUNT,
		FETCH,
		PUSH,
		DONE
	} scan_state_e;

	scan_state_e      state;
	logic [2:0]       byte_cnt;
	logic [IDX_W-1:0] rec_idx;
	logic [IDX_W-1:0] rec_last;
	logic [7:0]       count_clip;
	console_cmd_t     cmd_r;

	function automatic console_op_e decode_op(input logic [7:0] op_byte);
		case (op_byte)
			8'd0:    return OP_NOP;
			8'd1:    return OP_WRITE;
			8'd2:    return OP_READ;
			8'd3:    return OP_OR;
			default: return OP_ILLEGAL;
		endcase
	endfunction

	assign count_clip = (i_rd_data > 8'(MAX_RECORDS)) ? 8'(MAX_RECORDS) : i_rd_data;

	// ==================================================
	// fsm
	// ==================================================

	// byte_cnt j in FETCH means byte j-1 of the record is on i_rd_data;
	// the address runs one step ahead, so PUSH already shows the next record
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state       <= IDLE;
			byte_cnt    <= '0;
			rec_idx     <= '0;
			rec_last    <= '0;
			o_rd_addr   <= '0;
			o_scan_done <= 1'b0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (i_start) begin
						o_rd_addr   <= '0;
						byte_cnt    <= '0;
						o_scan_done <= 1'b0;
						state       <= COUNT;
					end
				end
				COUNT: begin
					if (byte_cnt == 3'd0) begin
						o_rd_addr <= CMD_AW'(RECORD_BASE);
						byte_cnt  <= 3'd1;
					end else if (count_clip == 8'd0) begin
						// empty batch
						o_scan_done <= 1'b1;
						state       <= DONE;
					end else begin
						rec_last  <= IDX_W'(count_clip - 8'd1);
						rec_idx   <= '0;
						o_rd_addr <= o_rd_addr + 1'b1;
						byte_cnt  <= 3'd1;
						state     <= FETCH;
					end
				end
				FETCH: begin
					if (byte_cnt != 3'd4) begin
						o_rd_addr <= o_rd_addr + 1'b1;
						byte_cnt  <= byte_cnt + 1'b1;
					end else begin
						state <= PUSH;
					end
				end
				PUSH: begin
					// hold the record while the queue is full
					if (!i_full) begin
						if (rec_idx == rec_last) begin
							o_scan_done <= 1'b1;
							state       <= DONE;
						end else begin
							rec_idx   <= rec_idx + 1'b1;
							o_rd_addr <= o_rd_addr + 1'b1;
							byte_cnt  <= 3'd1;
							state     <= FETCH;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// record assembly
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			case (byte_cnt)
				3'd1: begin
					cmd_r.op  <= decode_op(i_rd_data);
					cmd_r.idx <= rec_idx;
				end
				3'd2:    cmd_r.addr[15:8] <= i_rd_data;
				3'd3:    cmd_r.addr[7:0]  <= i_rd_data;
				3'd4:    cmd_r.data       <= i_rd_data;
				default: cmd_r.data       <= cmd_r.data;
			endcase
		end
	end

	assign o_push = (state == PUSH) && !i_full;
	assign o_cmd  = cmd_r;

	// the queue's full level must hold back every push
	a_no_push_when_full: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(o_push) |-> !i_full);

endmodule

`default_nettype wire

//--- source/console_dpram.sv
/*
 * true dual-port byte RAM, one clock, read latency of one cycle on both ports
 * read during write returns the old byte, on the same port and across ports
 */
`default_nettype none

module console_dpram #(
	parameter int ADDR_W = 10
) (
	input  wire              clk,

	input  wire              i_a_wren,
	input  wire [ADDR_W-1:0] i_a_addr,
	input  wire [7:0]        i_a_din,
	output logic [7:0]       o_a_dout,

	input  wire              i_b_wren,
	input  wire [ADDR_W-1:0] i_b_addr,
	input  wire [7:0]        i_b_din,
	output logic [7:0]       o_b_dout
);

	logic [7:0] mem [2**ADDR_W];

	// port a
	always @(posedge clk) begin
		if (i_a_wren) begin
			mem[i_a_addr] <= i_a_din;
		end
		o_a_dout <= mem[i_a_addr];
	end

	// port b
	always @(posedge clk) begin
		if (i_b_wren) begin
			mem[i_b_addr] <= i_b_din;
		end
		o_b_dout <= mem[i_b_addr];
	end

endmodule

`default_nettype wire

//--- source/console_pkg.sv
/*
 * shared types of the console engine. a record is opcode, addr hi, addr lo, data
 * count bytes above MAX_RECORDS are clipped; QUEUE_DEPTH must be a power of two
 */
`default_nettype none

package console_pkg;

	// ==================================================
	// widths and limits
	// ==================================================

	// command RAM holds the count byte and up to 63 records
	localparam int CMD_AW      = 10;
	// one response byte per record
	localparam int RESP_AW     = 6;
	// register bus address width
	localparam int REG_AW      = 16;

	localparam int IDX_W       = 6;
	localparam int MAX_RECORDS = 63;
	// record k starts at 4*k + RECORD_BASE, byte 0 is the count
	localparam int RECORD_BASE = 4;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

	// response byte for an opcode outside 0..3
	localparam logic [7:0] RESP_ILLEGAL = 8'hEE;

	// ==================================================
	// opcodes and commands
	// ==================================================

	// opcode bytes 0..3 map straight onto the first four values
	typedef enum logic [2:0] {
		OP_NOP     = 3'd0,
		OP_WRITE   = 3'd1,
		OP_READ    = 3'd2,
		OP_OR      = 3'd3,
		OP_ILLEGAL = 3'd7
	} console_op_e;

	// decoded record, 33 bits
	typedef struct packed {
		console_op_e       op;
		logic [REG_AW-1:0] addr;
		logic [7:0]        data;
		logic [IDX_W-1:0]  idx;
	} console_cmd_t;

endpackage

`default_nettype wire
